//--- run.sh
#!/bin/sh
# Compile and run the song player testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module song_player_tb \
	--Mdir obj_dir -o song_player_sim

./obj_dir/song_player_sim > sim.log
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
	echo "Simulation reported errors"
	exit 1
fi
echo "Simulation finished without errors"

//--- tb/song_player_tb.sv
// ##########################################################
// Song player testbench, table driven song, pitch, pause,
// restart and empty-song tests with an error summary
// ##########################################################
`timescale 1ns/10ps
`include "song_params.svh"

module song_player_tb;

	localparam int TEST_TIMEOUT = 6000;    // Cycles per test
	localparam int PAUSE_LEAD   = 3;       // Cycles before the note end to pause

	typedef struct {
		int sel;                           // song_sel
		int first;                         // First row in the expected table
		int count;                         // Note starts to check
		int pause_at;                      // Note index to pause in, -1 for none
		bit to_done;                       // Run until song_done
	} test_t;

	logic       clk;
	logic       rst_n;
	logic       play;
	logic       restart;
	logic [1:0] song_sel;
	logic       tone;
	logic       note_start;
	logic [5:0] cur_note;
	logic       song_done;

	int     cyc;
	int     checks;
	int     errors;
	int     timeouts;
	integer seed;

	test_t tests [4] = '{
		'{0, 0, 26, -1, 1},                // Song 0 to its end
		'{0, 0, 6, 2, 0},                  // Song 0 with a pause
		'{1, 26, 8, -1, 0},                // Song 1 via restart
		'{3, 0, 0, -1, 1}                  // Empty song 3
	};

	// Song 0 records 0 to 25, then song 1 records 32 to 39
	int exp_note [34] = '{
		28, 40, 52, 0, 27, 39, 51, 0, 0, 0, 0, 0, 30,
		54, 0, 32, 56, 0, 33, 0, 35, 0, 25, 0, 27, 0,
		35, 42, 38, 37, 35, 38, 37, 35
	};
	int exp_beats [34] = '{
		48, 48, 48, 48, 48, 32, 16, 16, 32, 16, 16, 16, 48,
		48, 48, 48, 16, 48, 48, 48, 32, 32, 32, 16, 16, 16,
		36, 36, 54, 18, 18, 18, 18, 18
	};

	song_player dut0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.play       (play),
		.restart    (restart),
		.song_sel   (song_sel),
		.tone       (tone),
		.note_start (note_start),
		.cur_note   (cur_note),
		.song_done  (song_done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Half-period in clocks, semitone table shifted by octave
	function automatic int half_period(input int note);
		int oct;
		int semi;
		oct  = (note - 1) / 12;
		semi = (note - 1) % 12;
		return (int'(song_pkg::SEMI_HALF_PER[semi]) >> oct) * `TONE_DIV;
	endfunction

	task automatic step();
		@(posedge clk);
		#2;
		cyc++;
	endtask

	task automatic check(input bit ok, input string msg);
		checks++;
		assert (ok) else begin
			errors++;
			$display("ERR %0t: %s", $time, msg);
		end
	endtask

	task automatic hold_pause(input int len);
		int i;
		play = 1'b0;
		for (i = 0; i < len; i++) begin
			step();
			check(!tone, "tone not silent while paused");
			check(!note_start, "note_start while paused");
		end
		play = 1'b1;
	endtask

	task automatic run_test(input int t);
		int got;
		int waited;
		int idx;
		int prev_start;
		int prev_beats;
		int note_end;
		int last_edge;
		int hp;
		int plen;
		bit is_rest;
		bit skip_pitch;
		bit paused;
		bit prev_tone;
		bit finished;
		got        = 0;
		waited     = 0;
		prev_start = -1;
		prev_beats = 0;
		note_end   = 0;
		last_edge  = 0;
		hp         = 1;
		is_rest    = 1'b0;
		skip_pitch = 1'b0;
		paused     = 1'b0;
		prev_tone  = 1'b0;
		finished   = 1'b0;
		song_sel = 2'(tests[t].sel);
		restart  = 1'b1;
		play     = 1'b1;
		step();
		restart = 1'b0;
		while (!finished && waited < TEST_TIMEOUT) begin
			step();
			waited++;
			if (note_start) begin
				idx = tests[t].first + got;
				check(got < tests[t].count,
					$sformatf("test %0d: extra note_start with note %0d", t, cur_note));
				if (got < tests[t].count) begin
					check(cur_note == 6'(exp_note[idx]), $sformatf(
						"test %0d note %0d: cur_note %0d, expected %0d",
						t, got, cur_note, exp_note[idx]));
					if (prev_start >= 0)
						check(cyc - prev_start == prev_beats * `BEAT_CYCLES + 2, $sformatf(
							"test %0d note %0d: start spacing %0d, expected %0d",
							t, got, cyc - prev_start, prev_beats * `BEAT_CYCLES + 2));
					prev_start = cyc;
					prev_beats = exp_beats[idx];
					is_rest    = (exp_note[idx] == 0);
					hp         = is_rest ? 0 : half_period(exp_note[idx]);
					last_edge  = cyc + 1;     // Counter restarts on this edge
					note_end   = cyc + prev_beats * `BEAT_CYCLES;
					skip_pitch = 1'b0;
					got++;
				end
			end
			if (got > 0 && cyc < note_end && !skip_pitch) begin
				if (is_rest) begin
					check(!tone, $sformatf("test %0d: tone during rest", t));
				end else if (tone != prev_tone) begin
					check(cyc - last_edge == hp, $sformatf(
						"test %0d note %0d: toggle after %0d clocks, expected %0d",
						t, got - 1, cyc - last_edge, hp));
					last_edge = cyc;
				end else begin
					check(cyc - last_edge < hp, $sformatf(
						"test %0d note %0d: no toggle within %0d clocks",
						t, got - 1, hp));
					if (cyc - last_edge >= hp)
						last_edge = cyc;
				end
			end
			prev_tone = tone;
			if (tests[t].pause_at >= 0 && !paused && got == tests[t].pause_at + 1 &&
				cyc == note_end - PAUSE_LEAD) begin
				plen = 4 + ({$random(seed)} % 40);
				hold_pause(plen);
				prev_start += plen;            // Timer frozen for the pause
				note_end   += plen;
				skip_pitch  = 1'b1;            // Tone phase restarts on resume
				paused      = 1'b1;
				prev_tone   = 1'b0;
			end
			if (tests[t].to_done) begin
				if (song_done)
					finished = 1'b1;
			end else if (got == tests[t].count) begin
				finished = 1'b1;
			end
		end
		if (!finished) begin
			timeouts++;
			$display("TIMEOUT: test %0d did not finish within %0d cycles", t, TEST_TIMEOUT);
		end else if (tests[t].to_done) begin
			check(got == tests[t].count, $sformatf(
				"test %0d: %0d notes before song_done, expected %0d", t, got, tests[t].count));
			if (prev_start >= 0)
				check(cyc - prev_start == prev_beats * `BEAT_CYCLES + 2, $sformatf(
					"test %0d: song_done %0d clocks after last start", t, cyc - prev_start));
		end
	endtask

	initial begin
		int i;
		cyc      = 0;
		checks   = 0;
		errors   = 0;
		timeouts = 0;
		seed     = 58;
		rst_n    = 1'b0;
		play     = 1'b0;
		restart  = 1'b0;
		song_sel = 2'd0;
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		for (i = 0; i < 5; i++) begin   // Idle until play goes high
			step();
			check(!tone && !note_start && !song_done && cur_note == 6'd0,
				"outputs active after reset with play low");
		end
		for (i = 0; i < 4; i++)
			run_test(i);
		$display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- verilog/beat_timer.sv
// ##########################################################
// Beat timer, times a note as beats x BEAT_CYCLES clocks
// ##########################################################
`timescale 1ns/10ps
`include "song_params.svh"

module beat_timer (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   play,
	note_if.timer  nf
);

	localparam int BC = `BEAT_CYCLES;
	localparam int PW = $clog2(BC + 1);

	logic [PW-1:0] pre_cnt;                // Cycles left in this beat
	logic [5:0]    beat_cnt;               // Beats left, 0 when idle
	logic          last_cyc;

	assign last_cyc = (beat_cnt == 6'd1) && (pre_cnt == PW'(1));

	// A stale count from an aborted note must not end the new one
	assign nf.done = play && last_cyc && !nf.load;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pre_cnt  <= '0;
			beat_cnt <= 6'd0;
		end else if (nf.load) begin
			beat_cnt <= nf.beats;
			pre_cnt  <= play ? PW'(BC - 1) : PW'(BC);   // Load cycle is the first one
		end else if (play && beat_cnt != 6'd0) begin
			if (pre_cnt == PW'(1)) begin
				pre_cnt  <= PW'(BC);
				beat_cnt <= beat_cnt - 6'd1;
			end else begin
				pre_cnt <= pre_cnt - 1'b1;
			end
		end
	end

endmodule

//--- verilog/note_if.sv
// ##########################################################
// Current note from the sequencer to timer and tone block
// ##########################################################
`timescale 1ns/10ps

interface note_if;

	logic [5:0] note;                  // Semitone number
	logic [5:0] beats;                 // Note length in beats
	logic       load;                  // New note strobe
	logic       done;                  // Last cycle of the note

	modport seq (output note, output beats, output load, input done);

	modport timer (input beats, input load, output done);

	modport tone (input note, input load);

endinterface

//--- verilog/song_params.svh
// ##########################################################
// Song player timing and ROM geometry
// ##########################################################
`ifndef SONG_PARAMS_SVH
`define SONG_PARAMS_SVH

// Clocks per beat, at least 2; raise for hardware
`define BEAT_CYCLES 4

// Clocks per tone tick
`define TONE_DIV 1

// Song ROM address width
`define ROM_AW 7

// song_sel to base address
`define SONG_BASE_SHIFT 5

`endif

//--- verilog/song_pkg.sv
// ##########################################################
// Song player types: sequencer states, ROM note record
// and the base-octave semitone half-period table
// ##########################################################
package song_pkg;

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		LOAD,
		PLAY,
		DONE
	} seq_state_t;

	typedef struct packed {
		logic       flag;                  // Unused by the player
		logic [5:0] note;                  // Semitones above A, 0 is a rest
		logic [5:0] beats;                 // 0 ends the song
		logic [2:0] rsvd;
	} note_rec_t;

	// Half-period in tone ticks, A through G# of the lowest octave
	localparam logic [15:0] SEMI_HALF_PER [12] = '{
		16'd128, 16'd121, 16'd114, 16'd108, 16'd102, 16'd96,
		16'd91, 16'd85, 16'd81, 16'd76, 16'd72, 16'd68
	};

endpackage

//--- verilog/song_player.sv
// ##########################################################
// Song player top, ROM, sequencer, beat timer and tone
// ##########################################################
`timescale 1ns/10ps
`include "song_params.svh"

module song_player (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        play,
	input  logic        restart,
	input  logic [1:0]  song_sel,
	output logic        tone,
	output logic        note_start,
	output logic [5:0]  cur_note,
	output logic        song_done
);

	note_if note_bus ();

	song_pkg::note_rec_t  rom_data;
	logic [`ROM_AW-1:0]   rom_addr;
	logic                 tone_en;

	song_rom u_rom (
		.clk  (clk),
		.addr (rom_addr),
		.dout (rom_data)
	);

	song_sequencer u_seq (
		.clk        (clk),
		.rst_n      (rst_n),
		.play       (play),
		.restart    (restart),
		.song_sel   (song_sel),
		.rom_data   (rom_data),
		.rom_addr   (rom_addr),
		.tone_en    (tone_en),
		.note_start (note_start),
		.song_done  (song_done),
		.cur_note   (cur_note),
		.nf         (note_bus.seq)
	);

	beat_timer u_timer (
		.clk   (clk),
		.rst_n (rst_n),
		.play  (play),
		.nf    (note_bus.timer)
	);

	tone_gen u_tone (
		.clk     (clk),
		.rst_n   (rst_n),
		.tone_en (tone_en),
		.tone    (tone),
		.nf      (note_bus.tone)
	);

endmodule

//--- verilog/song_rom.sv
// ##########################################################
// Song ROM, 128 note records with one clock read latency
// Songs at 0 and 32, unlisted entries end a song
// ##########################################################
`timescale 1ns/10ps
`include "song_params.svh"

module song_rom (
	input  logic                   clk,
	input  logic [`ROM_AW-1:0]     addr,
	output song_pkg::note_rec_t    dout
);

	always_ff @(posedge clk) begin
		case (addr)
			7'd0:  dout <= {1'b0, 6'd28, 6'd48, 3'b000};     // 3C
			7'd1:  dout <= {1'b0, 6'd40, 6'd48, 3'b000};     // 4C
			7'd2:  dout <= {1'b0, 6'd52, 6'd48, 3'b000};     // 5C
			7'd3:  dout <= {1'b1, 6'd0, 6'd48, 3'b000};
			7'd4:  dout <= {1'b0, 6'd27, 6'd48, 3'b000};     // 3B
			7'd5:  dout <= {1'b0, 6'd39, 6'd32, 3'b000};     // 4B
			7'd6:  dout <= {1'b0, 6'd51, 6'd16, 3'b000};     // 5B
			7'd7:  dout <= {1'b1, 6'd0, 6'd16, 3'b000};
			7'd8:  dout <= {1'b0, 6'd0, 6'd32, 3'b000};
			7'd9:  dout <= {1'b1, 6'd0, 6'd16, 3'b000};
			7'd10: dout <= {1'b0, 6'd0, 6'd16, 3'b000};
			7'd11: dout <= {1'b1, 6'd0, 6'd16, 3'b000};
			7'd12: dout <= {1'b0, 6'd30, 6'd48, 3'b000};     // 3D
			7'd13: dout <= {1'b0, 6'd54, 6'd48, 3'b000};     // 5D
			7'd14: dout <= {1'b1, 6'd0, 6'd48, 3'b000};
			7'd15: dout <= {1'b0, 6'd32, 6'd48, 3'b000};     // 3E
			7'd16: dout <= {1'b0, 6'd56, 6'd16, 3'b000};     // 5E
			7'd17: dout <= {1'b1, 6'd0, 6'd48, 3'b000};
			7'd18: dout <= {1'b0, 6'd33, 6'd48, 3'b000};     // 3F
			7'd19: dout <= {1'b1, 6'd0, 6'd48, 3'b000};
			7'd20: dout <= {1'b0, 6'd35, 6'd32, 3'b000};     // 3G
			7'd21: dout <= {1'b1, 6'd0, 6'd32, 3'b000};
			7'd22: dout <= {1'b0, 6'd25, 6'd32, 3'b000};     // 3A
			7'd23: dout <= {1'b1, 6'd0, 6'd16, 3'b000};
			7'd24: dout <= {1'b0, 6'd27, 6'd16, 3'b000};     // 3B
			7'd25: dout <= {1'b1, 6'd0, 6'd16, 3'b000};      // Last record of song 0
			7'd32: dout <= {1'b1, 6'd35, 6'd36, 3'b000};     // 3G, song 1 starts
			7'd33: dout <= {1'b1, 6'd42, 6'd36, 3'b000};     // 4D
			7'd34: dout <= {1'b1, 6'd38, 6'd54, 3'b000};     // 4A#
			7'd35: dout <= {1'b1, 6'd37, 6'd18, 3'b000};     // 4A
			7'd36: dout <= {1'b1, 6'd35, 6'd18, 3'b000};     // 3G
			7'd37: dout <= {1'b1, 6'd38, 6'd18, 3'b000};     // 4A#
			7'd38: dout <= {1'b1, 6'd37, 6'd18, 3'b000};     // 4A
			7'd39: dout <= {1'b1, 6'd35, 6'd18, 3'b000};     // 3G
			7'd40: dout <= {1'b1, 6'd34, 6'd18, 3'b000};     // 3F#
			7'd41: dout <= {1'b1, 6'd37, 6'd18, 3'b000};     // 4A
			7'd42: dout <= {1'b1, 6'd30, 6'd36, 3'b000};     // 3D
			7'd43: dout <= {1'b1, 6'd35, 6'd18, 3'b000};     // 3G
			7'd44: dout <= {1'b1, 6'd30, 6'd18, 3'b000};     // 3D
			7'd45: dout <= {1'b1, 6'd37, 6'd18, 3'b000};     // 4A
			7'd46: dout <= {1'b1, 6'd30, 6'd18, 3'b000};     // 3D
			7'd47: dout <= {1'b1, 6'd38, 6'd18, 3'b000};     // 4A#
			7'd48: dout <= {1'b1, 6'd37, 6'd9, 3'b000};      // 4A
			7'd49: dout <= {1'b1, 6'd35, 6'd9, 3'b000};      // 3G
			7'd50: dout <= {1'b1, 6'd37, 6'd18, 3'b000};     // 4A
			7'd51: dout <= {1'b1, 6'd30, 6'd18, 3'b000};     // 3D
			7'd52: dout <= {1'b1, 6'd35, 6'd18, 3'b000};     // 3G
			7'd53: dout <= {1'b1, 6'd30, 6'd9, 3'b000};      // 3D
			7'd54: dout <= {1'b1, 6'd35, 6'd9, 3'b000};      // 3G
			7'd55: dout <= {1'b1, 6'd37, 6'd18, 3'b000};     // 4A
			7'd56: dout <= {1'b1, 6'd30, 6'd9, 3'b000};      // 3D
			7'd57: dout <= {1'b1, 6'd37, 6'd9, 3'b000};      // 4A
			7'd58: dout <= {1'b1, 6'd38, 6'd18, 3'b000};     // 4A#
			7'd59: dout <= {1'b1, 6'd37, 6'd9, 3'b000};      // 4A
			7'd60: dout <= {1'b1, 6'd35, 6'd9, 3'b000};      // 3G
			7'd61: dout <= {1'b1, 6'd37, 6'd9, 3'b000};      // 4A
			7'd62: dout <= {1'b1, 6'd30, 6'd9, 3'b000};      // 3D
			7'd63: dout <= {1'b1, 6'd42, 6'd9, 3'b000};      // 4D
			7'd64: dout <= {1'b1, 6'd43, 6'd6, 3'b000};      // 4D#
			7'd65: dout <= {1'b1, 6'd44, 6'd8, 3'b000};      // 4E
			7'd66: dout <= {1'b1, 6'd0, 6'd34, 3'b000};
			7'd67: dout <= {1'b1, 6'd46, 6'd6, 3'b000};      // 4F#
			7'd68: dout <= {1'b1, 6'd47, 6'd8, 3'b000};      // 4G
			7'd69: dout <= {1'b1, 6'd0, 6'd34, 3'b000};
			7'd70: dout <= {1'b1, 6'd43, 6'd6, 3'b000};      // 4D#
			7'd71: dout <= {1'b1, 6'd44, 6'd8, 3'b000};      // 4E
			7'd72: dout <= {1'b1, 6'd0, 6'd10, 3'b000};
			7'd73: dout <= {1'b1, 6'd46, 6'd6, 3'b000};      // 4F#
			7'd74: dout <= {1'b1, 6'd47, 6'd8, 3'b000};      // 4G
			7'd75: dout <= {1'b1, 6'd0, 6'd10, 3'b000};
			7'd76: dout <= {1'b1, 6'd52, 6'd6, 3'b000};      // 5C
			7'd77: dout <= {1'b1, 6'd51, 6'd8, 3'b000};      // 5B
			7'd78: dout <= {1'b1, 6'd0, 6'd10, 3'b000};
			7'd79: dout <= {1'b1, 6'd44, 6'd6, 3'b000};      // 4E
			7'd80: dout <= {1'b1, 6'd47, 6'd8, 3'b000};      // 4G
			7'd81: dout <= {1'b1, 6'd0, 6'd10, 3'b000};
			7'd82: dout <= {1'b1, 6'd51, 6'd6, 3'b000};      // 5B
			7'd83: dout <= {1'b1, 6'd50, 6'd56, 3'b000};     // 5A#
			7'd84: dout <= {1'b1, 6'd49, 6'd8, 3'b000};      // 5A
			7'd85: dout <= {1'b1, 6'd47, 6'd8, 3'b000};      // 4G
			7'd86: dout <= {1'b1, 6'd44, 6'd8, 3'b000};      // 4E
			7'd87: dout <= {1'b1, 6'd42, 6'd8, 3'b000};      // 4D
			7'd88: dout <= {1'b1, 6'd44, 6'd40, 3'b000};     // 4E
			7'd89: dout <= {1'b1, 6'd0, 6'd60, 3'b000};
			7'd90: dout <= {1'b1, 6'd43, 6'd6, 3'b000};      // 4D#
			7'd91: dout <= {1'b1, 6'd44, 6'd14, 3'b000};     // 4E
			7'd92: dout <= {1'b1, 6'd0, 6'd28, 3'b000};
			7'd93: dout <= {1'b1, 6'd46, 6'd6, 3'b000};      // 4F#
			7'd94: dout <= {1'b1, 6'd47, 6'd16, 3'b000};     // 4G
			7'd95: dout <= {1'b1, 6'd0, 6'd26, 3'b000};
			default: dout <= {1'b1, 6'd0, 6'd0, 3'b000};     // Empty, zero beats
		endcase
	end

endmodule

//--- verilog/song_sequencer.sv
// ##########################################################
// Song sequencer FSM, walks the ROM from the selected base
// and hands each note to the beat timer and tone generator
// ##########################################################
`timescale 1ns/10ps
`include "song_params.svh"

module song_sequencer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   play,
	input  logic                   restart,
	input  logic [1:0]             song_sel,
	input  song_pkg::note_rec_t    rom_data,
	output logic [`ROM_AW-1:0]     rom_addr,
	output logic                   tone_en,
	output logic                   note_start,
	output logic                   song_done,
	output logic [5:0]             cur_note,
	note_if.seq                    nf
);

	localparam int AW = `ROM_AW;

	song_pkg::seq_state_t state;
	song_pkg::seq_state_t state_nxt;
	logic [AW-1:0] base_addr;
	logic          wrapped;                // Advanced past the last address
	logic          song_end;
	logic          load_q;
	logic [5:0]    note_q;
	logic [5:0]    beats_q;

	assign base_addr = AW'(song_sel) << `SONG_BASE_SHIFT;
	assign song_end  = (rom_data.beats == 6'd0) || wrapped;

	always_comb begin
		state_nxt = state;
		if (restart) begin
			state_nxt = song_pkg::FETCH;
		end else if (play) begin
			case (state)
				song_pkg::IDLE:  state_nxt = song_pkg::FETCH;
				song_pkg::FETCH: state_nxt = song_pkg::LOAD;
				song_pkg::LOAD:  state_nxt = song_end ? song_pkg::DONE : song_pkg::PLAY;
				song_pkg::PLAY:  state_nxt = nf.done ? song_pkg::FETCH : song_pkg::PLAY;
				song_pkg::DONE:  state_nxt = song_pkg::DONE;   // Only restart leaves
				default:         state_nxt = song_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= song_pkg::IDLE;
			rom_addr <= '0;
			wrapped  <= 1'b0;
			load_q   <= 1'b0;
			note_q   <= 6'd0;
			beats_q  <= 6'd0;
		end else begin
			state  <= state_nxt;
			load_q <= 1'b0;
			if (restart || (state == song_pkg::IDLE && state_nxt == song_pkg::FETCH)) begin
				rom_addr <= base_addr;         // Start of the selected song
				wrapped  <= 1'b0;
			end else if (state == song_pkg::PLAY && state_nxt == song_pkg::FETCH) begin
				rom_addr <= rom_addr + 1'b1;
				wrapped  <= &rom_addr;
			end else if (state == song_pkg::LOAD && state_nxt == song_pkg::PLAY) begin
				load_q  <= 1'b1;               // Strobe lands in the first PLAY cycle
				note_q  <= rom_data.note;
				beats_q <= rom_data.beats;
			end
		end
	end

	assign nf.note    = note_q;
	assign nf.beats   = beats_q;
	assign nf.load    = load_q;
	assign note_start = load_q;
	assign cur_note   = note_q;
	assign song_done  = (state == song_pkg::DONE);
	assign tone_en    = (state == song_pkg::PLAY) && play;

endmodule

//--- verilog/tone_gen.sv
// ##########################################################
// Tone generator, square wave at the pitch of the current
// note, half-period from the semitone table by octave
// ##########################################################
`timescale 1ns/10ps
`include "song_params.svh"

module tone_gen (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  tone_en,
	output logic  tone,
	note_if.tone  nf
);

	localparam int DIV = `TONE_DIV;
	localparam int DW  = (DIV > 1) ? $clog2(DIV) : 1;

	logic [DW-1:0] div_cnt;
	logic          tick;
	logic [5:0]    note_m1;
	logic [2:0]    octave;
	logic [5:0]    oct_base;
	logic [3:0]    semi;
	logic [15:0]   half_per;
	logic [15:0]   per_cnt;
	logic          tone_q;
	logic          sounding;

	assign note_m1 = nf.note - 6'd1;

	always_comb begin
		if (note_m1 >= 6'd60)
			octave = 3'd5;
		else if (note_m1 >= 6'd48)
			octave = 3'd4;
		else if (note_m1 >= 6'd36)
			octave = 3'd3;
		else if (note_m1 >= 6'd24)
			octave = 3'd2;
		else if (note_m1 >= 6'd12)
			octave = 3'd1;
		else
			octave = 3'd0;
	end

	assign oct_base = 6'd12 * {3'd0, octave};
	assign semi     = 4'(note_m1 - oct_base);
	assign half_per = song_pkg::SEMI_HALF_PER[semi] >> octave;

	assign sounding = tone_en && (nf.note != 6'd0);     // Rests stay silent
	assign tick     = (div_cnt == DW'(DIV - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			per_cnt <= 16'd0;
			tone_q  <= 1'b0;
		end else if (nf.load) begin
			div_cnt <= '0;                     // Phase starts at the new note
			per_cnt <= 16'd0;
			tone_q  <= 1'b0;
		end else if (!sounding) begin
			tone_q <= 1'b0;                    // Count held while paused
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick) begin
				if (per_cnt + 16'd1 >= half_per) begin
					per_cnt <= 16'd0;
					tone_q  <= ~tone_q;
				end else begin
					per_cnt <= per_cnt + 16'd1;
				end
			end
		end
	end

	assign tone = tone_q && sounding;

endmodule

//--- vlog.f
+incdir+verilog
verilog/song_pkg.sv
verilog/note_if.sv
verilog/song_rom.sv
verilog/song_sequencer.sv
verilog/beat_timer.sv
verilog/tone_gen.sv
verilog/song_player.sv
tb/song_player_tb.sv
